//--- dv/apu_cases.txt
// core unit op opa opb value flag, all fields hex
// unit 0 multiplier (op 0 low, 1 high word), unit 1 divider (op 0 quotient, 1 remainder)
0 0 0 00000003 00000005 0000000f 0
1 0 1 ffffffff ffffffff fffffffe 0
2 0 0 ffffffff ffffffff 00000001 0
3 0 1 00010000 00010000 00000001 0
0 1 0 00000064 00000007 0000000e 0
1 0 0 12345678 00000010 23456780 0
2 1 1 00000064 00000007 00000002 0
3 0 1 12345678 00000010 00000001 0
0 0 1 80000000 00000002 00000001 0
1 1 0 12345678 00000000 ffffffff 1
2 0 0 0000ffff 0000ffff fffe0001 0
3 1 1 12345678 00000000 12345678 1
0 1 0 ffffffff 00000010 0fffffff 0
1 0 1 abcd0000 00010000 0000abcd 0
2 1 0 00000005 00000009 00000000 0
3 0 0 ffffffff 00000002 fffffffe 0
0 1 1 ffffffff 00000010 0000000f 0
1 0 0 00000007 00000009 0000003f 0
2 1 1 00000005 00000009 00000005 0
3 0 1 ffffffff 00000002 00000001 0
0 0 0 deadbeef 00000001 deadbeef 0
1 1 1 deadbeef 00010000 0000beef 0
2 0 1 40000000 00000008 00000002 0
3 1 0 80000000 00000002 40000000 0
0 1 0 000003e8 0000000a 00000064 0
1 1 0 deadbeef 00010000 0000dead 0
2 1 0 00000000 00000003 00000000 0
3 1 0 00000007 00000007 00000001 0
0 1 1 00000000 00000000 00000000 1

//--- apu_cluster.f
+incdir+verilog
verilog/apu_pkg.sv
verilog/apu_splitter.sv
verilog/apu_arbiter.sv
verilog/apu_mult.sv
verilog/apu_div.sv
verilog/apu_cluster.sv
dv/tb_apu_cluster.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   -f apu_cluster.f \
   --top-module tb_apu_cluster \
   -o Vtb_apu_cluster
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_apu_cluster)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- dv/tb_apu_cluster.sv
////////////////////////////////////////////////////////////////////////////
// Cluster testbench with case file stimulus, random back-pressure and checks
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

module tb_apu_cluster import apu_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NB          = `APU_NB_CORES;
   localparam int ACK_TIMEOUT = 1000;
   localparam int RES_TIMEOUT = 1000;
   localparam int RUN_TIMEOUT = 20000;

   typedef struct packed {
      core_req_t   req;
      apu_result_t exp;
   } case_t;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic [NB-1:0]     req_ds;
   core_req_t         req [NB];
   logic [NB-1:0]     ack_ds;
   logic [NB-1:0]     valid_us;
   apu_result_t       result [NB];
   logic [NB-1:0]     ready_us = '0;

   case_t             core_cases [NB][$];
   logic [31:0]       rng_state = 32'h0041_a6c7;
   int                done_cnt;
   int                result_errs;
   int                proto_errs;
   int                timeouts;
   int                xfer_cnt [NB];
   logic [NB-1:0]     held;
   apu_result_t       held_res [NB];
   // Cores with a divide accepted and its result not yet taken
   logic [NB-1:0]     div_open;
   int                overtakes;

   apu_cluster i_apu_cluster (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_ds_i   (req_ds),
      .req_i      (req),
      .ack_ds_o   (ack_ds),
      .valid_us_o (valid_us),
      .result_o   (result),
      .ready_us_i (ready_us)
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Ready is high about three cycles in four
   always @(negedge clk_i) begin
      rng_state = xorshift32(rng_state);
      for (int c = 0; c < NB; c++) begin
         ready_us[c] = rng_state[c] | rng_state[c + 16];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_result(input int core, input apu_result_t got,
                               input apu_result_t exp);
      if (got !== exp) begin
         $display("** Error @ %0t: core %0d result %h flag %b, expected %h flag %b",
                  $time, core, got.value, got.div_zero, exp.value, exp.div_zero);
         result_errs++;
      end
   endtask

   task automatic verify_stable(input int core, input apu_result_t got,
                                input apu_result_t prev);
      if (got !== prev) begin
         $display("** Error @ %0t: core %0d result changed from %h to %h while held",
                  $time, core, prev, got);
         proto_errs++;
      end
   endtask

   task automatic expect_low(input string what, input logic [NB-1:0] got);
      if (got !== '0) begin
         $display("** Error @ %0t: %s is %b after reset, expected all low",
                  $time, what, got);
         proto_errs++;
      end
   endtask

   // Upstream monitor sampling inside the low clock phase
   always @(negedge clk_i) begin
      #1;
      for (int c = 0; c < NB; c++) begin
         if (valid_us[c]) begin
            if (held[c]) begin
               verify_stable(c, result[c], held_res[c]);
            end
            held_res[c] = result[c];
            held[c]     = !ready_us[c];
            if (ready_us[c]) begin
               xfer_cnt[c]++;
            end
         end else if (held[c]) begin
            $display("Core %0d dropped valid_us before the result was taken", c);
            proto_errs++;
            held[c] = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic load_cases();
      int          fd;
      int          n;
      int          core_n;
      int          unit_n;
      int          op_n;
      int          flag_n;
      logic [31:0] opa;
      logic [31:0] opb;
      logic [31:0] val;
      string       line;
      case_t       cs;
      fd = $fopen("dv/apu_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the case file dv/apu_cases.txt");
         proto_errs++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.substr(0, 1) == "//") begin
            continue;
         end
         n = $sscanf(line, "%h %h %h %h %h %h %h",
                     core_n, unit_n, op_n, opa, opb, val, flag_n);
         if (n != 7 || core_n < 0 || core_n >= NB) begin
            $display("Malformed line in the case file: %s", line);
            proto_errs++;
            continue;
         end
         cs.req.unit         = apu_type_e'(unit_n[0]);
         cs.req.op           = op_n[0];
         cs.req.opa          = opa;
         cs.req.opb          = opb;
         cs.exp.value        = val;
         cs.exp.div_zero     = flag_n[0];
         core_cases[core_n].push_back(cs);
      end
      $fclose(fd);
   endtask

   // One request at a time with the next one only after the result is taken
   task automatic run_core(input int core);
      case_t cs;
      int    wait_cnt;
      bit    got;
      for (int n = 0; n < core_cases[core].size(); n++) begin
         cs = core_cases[core][n];
         @(negedge clk_i);
         req[core]    = cs.req;
         req_ds[core] = 1'b1;
         got      = 1'b0;
         wait_cnt = 0;
         while (!got && wait_cnt < ACK_TIMEOUT) begin
            #1;
            got = ack_ds[core];
            if (!got) begin
               wait_cnt++;
               @(negedge clk_i);
            end
         end
         if (!got) begin
            $display("Core %0d got no acknowledge within %0d cycles", core, ACK_TIMEOUT);
            timeouts++;
            req_ds[core] = 1'b0;
            break;
         end
         @(negedge clk_i);
         req_ds[core] = 1'b0;
         if (cs.req.unit == DIV) begin
            div_open[core] = 1'b1;
         end
         got      = 1'b0;
         wait_cnt = 0;
         while (!got && wait_cnt < RES_TIMEOUT) begin
            #1;
            got = valid_us[core] && ready_us[core];
            if (!got) begin
               wait_cnt++;
               @(negedge clk_i);
            end
         end
         if (!got) begin
            $display("Core %0d got no result within %0d cycles", core, RES_TIMEOUT);
            timeouts++;
            break;
         end
         check_result(core, result[core], cs.exp);
         if (cs.req.unit == MULT && div_open != '0) begin
            overtakes++;
         end
         // Upstream transfer completes on this edge
         @(posedge clk_i);
         div_open[core] = 1'b0;
      end
      done_cnt++;
   endtask

   initial begin
      int wait_cnt;
      rst_i     = 1'b1;
      req_ds    = '0;
      held      = '0;
      div_open  = '0;
      overtakes = 0;
      for (int c = 0; c < NB; c++) begin
         req[c]      = '0;
         xfer_cnt[c] = 0;
      end
      load_cases();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      #1;
      expect_low("ack_ds_o", ack_ds);
      expect_low("valid_us_o", valid_us);

      // All cores start on the same edge and every first case is a multiply
      for (int c = 0; c < NB; c++) begin
         automatic int core = c;
         fork
            run_core(core);
         join_none
      end

      wait_cnt = 0;
      while (done_cnt < NB && wait_cnt < RUN_TIMEOUT) begin
         @(negedge clk_i);
         wait_cnt++;
      end
      if (done_cnt < NB) begin
         $display("Cores did not finish within %0d cycles", RUN_TIMEOUT);
         timeouts++;
      end

      // Window for a stray or duplicated result to show up
      repeat (`APU_DIV_CYCLES + 8) @(negedge clk_i);
      for (int c = 0; c < NB; c++) begin
         if (xfer_cnt[c] != core_cases[c].size()) begin
            $display("Core %0d received %0d results for %0d requests",
                     c, xfer_cnt[c], core_cases[c].size());
            proto_errs++;
         end
      end

      // Multiplies keep completing while the divider works
      if (overtakes == 0) begin
         $display("No multiply result was returned while a divide was in flight");
         proto_errs++;
      end

      $display("Errors: %0d result, %0d protocol, %0d timeout",
               result_errs, proto_errs, timeouts);
      if (result_errs == 0 && proto_errs == 0 && timeouts == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/apu_cluster.sv
////////////////////////////////////////////////////////////////////////////
// Shared multiplier and divider cluster with per-core splitters and arbiters
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

module apu_cluster import apu_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic [`APU_NB_CORES-1:0] req_ds_i,
   input  core_req_t                req_i [`APU_NB_CORES],
   output logic [`APU_NB_CORES-1:0] ack_ds_o,
   output logic [`APU_NB_CORES-1:0] valid_us_o,
   output apu_result_t              result_o [`APU_NB_CORES],
   input  logic [`APU_NB_CORES-1:0] ready_us_i
);

   // Splitter to arbiter, multiplier side
   logic [`APU_NB_CORES-1:0] mult_req;
   mult_req_t                mult_pl [`APU_NB_CORES];
   logic [`APU_NB_CORES-1:0] mult_ack;
   logic [`APU_NB_CORES-1:0] mult_valid;
   apu_result_t              mult_res [`APU_NB_CORES];

   // Splitter to arbiter, divider side
   logic [`APU_NB_CORES-1:0] div_req;
   div_req_t                 div_pl [`APU_NB_CORES];
   logic [`APU_NB_CORES-1:0] div_ack;
   logic [`APU_NB_CORES-1:0] div_valid;
   apu_result_t              div_res [`APU_NB_CORES];

   logic [`APU_NB_CORES-1:0] core_ready;

   // Arbiter to unit
   logic                  mult_in_valid;
   mult_req_t             mult_in;
   logic [`APU_TAG_W-1:0] mult_in_tag;
   logic                  mult_in_ready;
   logic                  mult_out_valid;
   tagged_result_t        mult_out;
   logic                  mult_out_ready;

   logic                  div_in_valid;
   div_req_t              div_in;
   logic [`APU_TAG_W-1:0] div_in_tag;
   logic                  div_in_ready;
   logic                  div_out_valid;
   tagged_result_t        div_out;
   logic                  div_out_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Per-core splitters
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `APU_NB_CORES; i++) begin : g_core
      apu_splitter i_splitter (
         .req_ds_i     (req_ds_i[i]),
         .req_i        (req_i[i]),
         .ack_ds_o     (ack_ds_o[i]),
         .valid_us_o   (valid_us_o[i]),
         .result_o     (result_o[i]),
         .ready_us_i   (ready_us_i[i]),
         .mult_req_o   (mult_req[i]),
         .mult_pl_o    (mult_pl[i]),
         .mult_ack_i   (mult_ack[i]),
         .mult_valid_i (mult_valid[i]),
         .mult_res_i   (mult_res[i]),
         .div_req_o    (div_req[i]),
         .div_pl_o     (div_pl[i]),
         .div_ack_i    (div_ack[i]),
         .div_valid_i  (div_valid[i]),
         .div_res_i    (div_res[i]),
         .ready_us_o   (core_ready[i])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // Multiplier path
   ////////////////////////////////////////////////////////////////////////////

   apu_arbiter #(.payload_t(mult_req_t)) i_mult_arbiter (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (mult_req),
      .pl_i             (mult_pl),
      .ack_o            (mult_ack),
      .valid_o          (mult_valid),
      .res_o            (mult_res),
      .ready_i          (core_ready),
      .unit_valid_o     (mult_in_valid),
      .unit_pl_o        (mult_in),
      .unit_tag_o       (mult_in_tag),
      .unit_ready_i     (mult_in_ready),
      .unit_out_valid_i (mult_out_valid),
      .unit_out_i       (mult_out),
      .unit_out_ready_o (mult_out_ready)
   );

   apu_mult i_mult (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (mult_in_valid),
      .in_i        (mult_in),
      .in_tag_i    (mult_in_tag),
      .in_ready_o  (mult_in_ready),
      .out_valid_o (mult_out_valid),
      .out_o       (mult_out),
      .out_ready_i (mult_out_ready)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Divider path
   ////////////////////////////////////////////////////////////////////////////

   apu_arbiter #(.payload_t(div_req_t)) i_div_arbiter (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (div_req),
      .pl_i             (div_pl),
      .ack_o            (div_ack),
      .valid_o          (div_valid),
      .res_o            (div_res),
      .ready_i          (core_ready),
      .unit_valid_o     (div_in_valid),
      .unit_pl_o        (div_in),
      .unit_tag_o       (div_in_tag),
      .unit_ready_i     (div_in_ready),
      .unit_out_valid_i (div_out_valid),
      .unit_out_i       (div_out),
      .unit_out_ready_o (div_out_ready)
   );

   apu_div i_div (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (div_in_valid),
      .in_i        (div_in),
      .in_tag_i    (div_in_tag),
      .in_ready_o  (div_in_ready),
      .out_valid_o (div_out_valid),
      .out_o       (div_out),
      .out_ready_i (div_out_ready)
   );

endmodule

//--- verilog/apu_div.sv
////////////////////////////////////////////////////////////////////////////
// Iterative unsigned divider, quotient or remainder, divide-by-zero flag
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

module apu_div import apu_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  in_valid_i,
   input  div_req_t              in_i,
   input  logic [`APU_TAG_W-1:0] in_tag_i,
   output logic                  in_ready_o,
   output logic                  out_valid_o,
   output tagged_result_t        out_o,
   input  logic                  out_ready_i
);

   logic                                busy;
   logic                                out_v;
   logic [$clog2(`APU_DIV_CYCLES)-1:0] cnt;
   logic                                accept;

   // Payload of the operation in progress
   div_op_e                op_q;
   logic [`APU_TAG_W-1:0]  tag_q;
   logic                   div_zero_q;
   logic [`APU_DATA_W-1:0] dvs_q;
   logic [`APU_DATA_W-1:0] rem_q;
   // Dividend bits shift out at the top while quotient bits enter at the bottom
   logic [`APU_DATA_W-1:0] qd_q;

   logic [`APU_DATA_W:0]   trial;
   logic [`APU_DATA_W:0]   diff;

   assign in_ready_o = !busy && !out_v;
   assign accept     = in_valid_i && in_ready_o;

   assign trial = {rem_q, qd_q[`APU_DATA_W-1]};
   assign diff  = trial - {1'b0, dvs_q};

   ////////////////////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy  <= 1'b0;
         out_v <= 1'b0;
         cnt   <= '0;
      end else if (accept) begin
         busy <= 1'b1;
         cnt  <= '0;
      end else if (busy) begin
         cnt <= cnt + 1'b1;
         if (int'(cnt) == `APU_DIV_CYCLES - 1) begin
            busy  <= 1'b0;
            out_v <= 1'b1;
         end
      end else if (out_v && out_ready_i) begin
         out_v <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Restoring shift-subtract datapath
   ////////////////////////////////////////////////////////////////////////////

   // A zero divisor never fails the subtract, so the quotient ends all ones
   // and the remainder ends equal to the dividend
   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q       <= in_i.op;
         tag_q      <= in_tag_i;
         div_zero_q <= (in_i.opb == '0);
         dvs_q      <= in_i.opb;
         qd_q       <= in_i.opa;
         rem_q      <= '0;
      end else if (busy) begin
         if (!diff[`APU_DATA_W]) begin
            rem_q <= diff[`APU_DATA_W-1:0];
            qd_q  <= {qd_q[`APU_DATA_W-2:0], 1'b1};
         end else begin
            rem_q <= trial[`APU_DATA_W-1:0];
            qd_q  <= {qd_q[`APU_DATA_W-2:0], 1'b0};
         end
      end
   end

   // Held stable from the registers until the result is taken
   assign out_valid_o        = out_v;
   assign out_o.tag          = tag_q;
   assign out_o.res.value    = (op_q == DIV_REM) ? rem_q : qd_q;
   assign out_o.res.div_zero = div_zero_q;

endmodule

//--- verilog/apu_mult.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined 32-bit unsigned multiplier, low or high product word
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

module apu_mult import apu_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  in_valid_i,
   input  mult_req_t             in_i,
   input  logic [`APU_TAG_W-1:0] in_tag_i,
   output logic                  in_ready_o,
   output logic                  out_valid_o,
   output tagged_result_t        out_o,
   input  logic                  out_ready_i
);

   logic [`APU_MULT_STAGES-1:0] st_v;
   logic [`APU_TAG_W-1:0]       st_tag [`APU_MULT_STAGES];
   mult_op_e                    st_op [`APU_MULT_STAGES];
   // Stage 0 keeps the two partial products, later stages the full product
   logic [47:0]                 pp_lo;
   logic [47:0]                 pp_hi;
   logic [63:0]                 st_prod [1:`APU_MULT_STAGES-1];
   logic                        advance;

   // Whole pipe moves together, frozen while the last stage is held
   assign advance    = !st_v[`APU_MULT_STAGES-1] || out_ready_i;
   assign in_ready_o = advance;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         st_v <= '0;
      end else if (advance) begin
         st_v <= {st_v[`APU_MULT_STAGES-2:0], in_valid_i};
      end
   end

   always_ff @(posedge clk_i) begin
      if (advance) begin
         st_tag[0] <= in_tag_i;
         st_op[0]  <= in_i.op;
         // Split on the halves of operand b
         pp_lo <= in_i.opa * in_i.opb[15:0];
         pp_hi <= in_i.opa * in_i.opb[31:16];
         st_prod[1] <= {16'b0, pp_lo} + {pp_hi, 16'b0};
         for (int s = 1; s < `APU_MULT_STAGES; s++) begin
            st_tag[s] <= st_tag[s-1];
            st_op[s]  <= st_op[s-1];
         end
         for (int s = 2; s < `APU_MULT_STAGES; s++) begin
            st_prod[s] <= st_prod[s-1];
         end
      end
   end

   assign out_valid_o = st_v[`APU_MULT_STAGES-1];
   assign out_o.tag   = st_tag[`APU_MULT_STAGES-1];
   assign out_o.res.value = (st_op[`APU_MULT_STAGES-1] == MUL_HI) ?
                            st_prod[`APU_MULT_STAGES-1][63:32] :
                            st_prod[`APU_MULT_STAGES-1][31:0];
   assign out_o.res.div_zero = 1'b0;

endmodule

//--- verilog/apu_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter for one shared unit, tagging and result return
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

module apu_arbiter import apu_pkg::*; #(
   parameter type payload_t = mult_req_t
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic [`APU_NB_CORES-1:0] req_i,
   input  payload_t                 pl_i [`APU_NB_CORES],
   output logic [`APU_NB_CORES-1:0] ack_o,
   output logic [`APU_NB_CORES-1:0] valid_o,
   output apu_result_t              res_o [`APU_NB_CORES],
   input  logic [`APU_NB_CORES-1:0] ready_i,
   output logic                     unit_valid_o,
   output payload_t                 unit_pl_o,
   output logic [`APU_TAG_W-1:0]    unit_tag_o,
   input  logic                     unit_ready_i,
   input  logic                     unit_out_valid_i,
   input  tagged_result_t           unit_out_i,
   output logic                     unit_out_ready_o
);

   // Core with the highest priority in the next grant
   logic [`APU_TAG_W-1:0] rr_ptr;
   logic                  gnt_valid;
   logic [`APU_TAG_W-1:0] gnt_idx;
   logic                  grant;

   ////////////////////////////////////////////////////////////////////////////
   // Request side
   ////////////////////////////////////////////////////////////////////////////

   // First requesting core at or after the pointer, wrapping around
   always_comb begin
      int idx;
      gnt_valid = 1'b0;
      gnt_idx   = '0;
      for (int k = 0; k < `APU_NB_CORES; k++) begin
         idx = (int'(rr_ptr) + k) % `APU_NB_CORES;
         if (!gnt_valid && req_i[idx]) begin
            gnt_valid = 1'b1;
            gnt_idx   = idx[`APU_TAG_W-1:0];
         end
      end
   end

   assign unit_valid_o = gnt_valid;
   assign unit_pl_o    = pl_i[gnt_idx];
   assign unit_tag_o   = gnt_idx;
   assign grant        = gnt_valid && unit_ready_i;

   // Ack goes out in the same cycle the unit takes the request
   always_comb begin
      ack_o = '0;
      if (grant) begin
         ack_o[gnt_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rr_ptr <= '0;
      end else if (grant) begin
         if (int'(gnt_idx) == `APU_NB_CORES - 1) begin
            rr_ptr <= '0;
         end else begin
            rr_ptr <= gnt_idx + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Result side
   ////////////////////////////////////////////////////////////////////////////

   // Result is broadcast, valid only reaches the tagged core
   always_comb begin
      for (int c = 0; c < `APU_NB_CORES; c++) begin
         valid_o[c] = unit_out_valid_i && (int'(unit_out_i.tag) == c);
         res_o[c]   = unit_out_i.res;
      end
   end

   // Unit holds its output until the tagged core is ready
   assign unit_out_ready_o = ready_i[unit_out_i.tag];

endmodule

//--- verilog/apu_splitter.sv
////////////////////////////////////////////////////////////////////////////
// One core's request routing by unit type and result merging
////////////////////////////////////////////////////////////////////////////

module apu_splitter import apu_pkg::*; (
   input  logic        req_ds_i,
   input  core_req_t   req_i,
   output logic        ack_ds_o,
   output logic        valid_us_o,
   output apu_result_t result_o,
   input  logic        ready_us_i,
   output logic        mult_req_o,
   output mult_req_t   mult_pl_o,
   input  logic        mult_ack_i,
   input  logic        mult_valid_i,
   input  apu_result_t mult_res_i,
   output logic        div_req_o,
   output div_req_t    div_pl_o,
   input  logic        div_ack_i,
   input  logic        div_valid_i,
   input  apu_result_t div_res_i,
   output logic        ready_us_o
);

   // Indexed by apu_type_e
   logic [1:0]  unit_valid;
   logic [1:0]  unit_ack;
   apu_result_t unit_res [2];

   // Request side, only the addressed unit sees a strobe and a payload
   always_comb begin
      mult_req_o = 1'b0;
      mult_pl_o  = '0;
      div_req_o  = 1'b0;
      div_pl_o   = '0;
      if (req_i.unit == MULT) begin
         mult_req_o = req_ds_i;
         mult_pl_o  = '{op: mult_op_e'(req_i.op), opa: req_i.opa, opb: req_i.opb};
      end else begin
         div_req_o = req_ds_i;
         div_pl_o  = '{op: div_op_e'(req_i.op), opa: req_i.opa, opb: req_i.opb};
      end
   end

   assign unit_valid[MULT] = mult_valid_i;
   assign unit_valid[DIV]  = div_valid_i;
   assign unit_ack[MULT]   = mult_ack_i;
   assign unit_ack[DIV]    = div_ack_i;
   assign unit_res[MULT]   = mult_res_i;
   assign unit_res[DIV]    = div_res_i;

   // Merge over unit types
   // One request outstanding per core, so at most one unit is valid here
   always_comb begin
      ack_ds_o   = 1'b0;
      valid_us_o = 1'b0;
      result_o   = '0;
      for (int t = 0; t < 2; t++) begin
         if (unit_valid[t]) begin
            valid_us_o = 1'b1;
            result_o   = unit_res[t];
         end
         if (unit_ack[t]) begin
            ack_ds_o = 1'b1;
         end
      end
   end

   // Both arbiters see the core's ready, only the owner of the result uses it
   assign ready_us_o = ready_us_i;

endmodule

//--- verilog/apu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Request, result and unit payload types, operation encodings
////////////////////////////////////////////////////////////////////////////

`include "apu_defs.svh"

package apu_pkg;

   // Unit selector carried by every core request
   typedef enum logic {
      MULT = 1'b0,
      DIV  = 1'b1
   } apu_type_e;

   typedef enum logic {
      MUL_LO = 1'b0,
      MUL_HI = 1'b1
   } mult_op_e;

   typedef enum logic {
      DIV_QUO = 1'b0,
      DIV_REM = 1'b1
   } div_op_e;

   typedef struct packed {
      mult_op_e                op;
      logic [`APU_DATA_W-1:0] opa;
      logic [`APU_DATA_W-1:0] opb;
   } mult_req_t;

   typedef struct packed {
      div_op_e                 op;
      logic [`APU_DATA_W-1:0] opa;
      logic [`APU_DATA_W-1:0] opb;
   } div_req_t;

   // Op bit is decoded against the unit type in the splitter
   typedef struct packed {
      apu_type_e               unit;
      logic                    op;
      logic [`APU_DATA_W-1:0] opa;
      logic [`APU_DATA_W-1:0] opb;
   } core_req_t;

   typedef struct packed {
      logic [`APU_DATA_W-1:0] value;
      logic                    div_zero;
   } apu_result_t;

   typedef struct packed {
      logic [`APU_TAG_W-1:0] tag;
      apu_result_t            res;
   } tagged_result_t;

endpackage

//--- verilog/apu_defs.svh
////////////////////////////////////////////////////////////////////////////
// Cluster-wide sizes: core count, data and tag widths, unit latencies
////////////////////////////////////////////////////////////////////////////

`ifndef APU_DEFS_SVH
`define APU_DEFS_SVH

// Cores sharing the arithmetic units
`define APU_NB_CORES 4

// Operand and result width
`define APU_DATA_W 32

// Width of a core number carried with each request
`define APU_TAG_W ($clog2(`APU_NB_CORES))

// Registered stages in the multiplier
`define APU_MULT_STAGES 3

// Shift-subtract iterations in the divider, one per dividend bit
`define APU_DIV_CYCLES 32

`endif
